/* smc_state_pkg.sv */
// Static memory controller state encoding
// State codes shared by the strobe generator and the outer controller FSM
// One-hot codes, one bit per controller state

`default_nettype none

package smc_state_pkg;

   localparam int STATE_W = 5;                    // Width of the state vector

   typedef logic [STATE_W-1:0] smc_state_t;

   // --------------------------------------
   // Controller states
   // --------------------------------------
   localparam smc_state_t SMC_IDLE  = 5'b00001;  // No access in progress
   localparam smc_state_t SMC_LE    = 5'b00010;  // Leading edge wait
   localparam smc_state_t SMC_RW    = 5'b00100;  // Read/write strobe phase
   localparam smc_state_t SMC_STORE = 5'b01000;  // Store read data
   localparam smc_state_t SMC_FLOAT = 5'b10000;  // Bus turnaround

endpackage : smc_state_pkg

`default_nettype wire

/* smc_timing_pkg.sv */
// Static memory controller timing fields
// Edge timing fields, the wait-state word and byte lane enables
// The wait-state word is read as one count or as hi/lo fields

`default_nettype none

package smc_timing_pkg;

   localparam int EDGE_W    = 2;                 // Edge field width
   localparam int WS_W      = 8;                 // Wait-state word width
   localparam int WS_HI_W   = 6;                 // Upper wait-state field
   localparam int NUM_BYTES = 4;                 // Byte lanes on the bus

   // Write leading/trailing edge or OE trailing edge
   typedef logic [EDGE_W-1:0] edge_t;

   // --------------------------------------
   // Wait-state word, two views
   // --------------------------------------
   typedef union packed {
      logic [WS_W-1:0] count;                    // Whole wait-state count
      struct packed {
         logic [WS_HI_W-1:0]      hi;            // Whole groups of four
         logic [WS_W-WS_HI_W-1:0] lo;            // Sub-group remainder
      } field;
   } ws_word_u;

   // Active-low lane enables
   typedef logic [NUM_BYTES-1:0] byte_en_t;

   localparam byte_en_t BYTE_NONE = '1;          // All lanes off

endpackage : smc_timing_pkg

`default_nettype wire

/* smc_cycle_hold.sv */
// Access hold register for the static memory controller
// Keeps read/write direction and chip select stable for a whole access,
// including multiple accesses, and flags the controller as busy

`timescale 1ns/1ps
`default_nettype none

module smc_cycle_hold
(
   input  wire                      sys_clk4,
   input  wire                      n_sys_reset4,   // Async, active low
   input  wire                      valid_access,   // New request this cycle
   input  wire                      n_read,         // Low for a read
   input  wire                      cs,             // Chip select of request
   input  wire                      smc_done,       // One access finished
   input  wire                      mac_done,       // Last of a multiple access
   input  wire smc_state_pkg::smc_state_t smc_nextstate,
   output logic                     n_r_read,       // Held direction
   output logic                     r_cs,           // Held chip select
   output logic                     smc_busy        // Controller active
);

   import smc_state_pkg::*;

   logic access_end;                                 // Whole access completed

   assign access_end = smc_done & mac_done;

   // --------------------------------------
   // Direction and chip select hold
   // --------------------------------------
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
      begin
         n_r_read <= 1'b0;
         r_cs     <= 1'b0;
      end
      else if (valid_access)                         // Request wins over done
      begin
         n_r_read <= n_read;
         r_cs     <= cs;
      end
      else if (access_end)
      begin
         n_r_read <= 1'b0;                           // Back to idle
         r_cs     <= 1'b0;
      end
   end

   // Busy whenever the FSM heads anywhere but idle
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         smc_busy <= 1'b0;
      else
         smc_busy <= (smc_nextstate != SMC_IDLE);
   end

   // Chip select released once the multiple access is over
   a_cs_release : assert property (@(posedge sys_clk4) disable iff (!n_sys_reset4)
      (!valid_access && smc_done && mac_done) |=> !r_cs);

endmodule : smc_cycle_hold

`default_nettype wire

/* smc_write_enable.sv */
// Write strobe generation for the static memory controller
// Registers the per-byte write enables, the general write strobe and
// the external bus output enable

`timescale 1ns/1ps
`default_nettype none

module smc_write_enable
(
   input  wire                      sys_clk4,
   input  wire                      n_sys_reset4,
   input  wire                      valid_access,   // New request this cycle
   input  wire                      n_read,         // High for a write
   input  wire                      n_r_read,       // Held direction
   input  wire smc_timing_pkg::byte_en_t  n_be,     // Unregistered lane enables
   input  wire smc_state_pkg::smc_state_t smc_nextstate,
   output smc_timing_pkg::byte_en_t n_r_we,         // Registered lane enables
   output logic                     n_r_wr,         // Write strobe, active low
   output logic                     smc_n_ext_oe    // Bus drivers on, active low
);

   import smc_state_pkg::*;
   import smc_timing_pkg::*;

   logic not_store;                                  // Strobes drop in store
   logic new_write;                                  // Write request this cycle
   logic held_write;                                 // Ongoing write access
   logic wr_active;

   assign not_store  = (smc_nextstate != SMC_STORE);
   assign new_write  = valid_access & n_read;
   assign held_write = ~valid_access & n_r_read;
   assign wr_active  = not_store & (new_write | held_write);

   // --------------------------------------
   // Lane enables and write strobe
   // --------------------------------------
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
      begin
         n_r_we <= BYTE_NONE;
         n_r_wr <= 1'b1;
      end
      else if (wr_active)
      begin
         n_r_we <= n_be;                             // Lanes of this write
         n_r_wr <= 1'b0;
      end
      else
      begin
         n_r_we <= BYTE_NONE;
         n_r_wr <= 1'b1;
      end
   end

   // Held write keeps drivers on only while the FSM is not going idle
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         smc_n_ext_oe <= 1'b1;
      else
         smc_n_ext_oe <= ~(not_store &
                           (new_write | (held_write & (smc_nextstate != SMC_IDLE))));
   end

   // Any enabled lane implies an active write strobe
   a_we_needs_wr : assert property (@(posedge sys_clk4) disable iff (!n_sys_reset4)
      (n_r_we != BYTE_NONE) |-> !n_r_wr);

endmodule : smc_write_enable

`default_nettype wire

/* smc_full_cycle.sv */
// Full-cycle write decision for the static memory controller
// Flags writes whose strobe must span a full clock cycle because wait
// states follow the write trailing edge

`timescale 1ns/1ps
`default_nettype none

module smc_full_cycle
(
   input  wire                      sys_clk4,
   input  wire                      n_sys_reset4,
   input  wire                      valid_access,       // New request
   input  wire                      smc_done,           // One access finished
   input  wire smc_state_pkg::smc_state_t r_smc_currentstate,
   input  wire smc_state_pkg::smc_state_t smc_nextstate,
   input  wire smc_timing_pkg::edge_t     r_wele_count, // Leading edge counter
   input  wire smc_timing_pkg::edge_t     r_wele_store, // Leading edge setting
   input  wire smc_timing_pkg::edge_t     r_wete_store, // Trailing edge setting
   input  wire smc_timing_pkg::ws_word_u  r_ws_count,   // Live wait-state count
   input  wire smc_timing_pkg::ws_word_u  r_ws_store,   // Stored wait states
   output logic                     r_full              // Full-cycle write
);

   import smc_state_pkg::*;
   import smc_timing_pkg::*;

   edge_t wete_next;                                 // Trailing edge plus one
   logic  le_short;                                  // Leading edge count < 2
   logic  cnt_long;                                  // Live count past edge
   logic  store_long;                                // Stored word past edge
   logic  cnt_long_next;                             // Past edge plus one
   logic  cnt_over4;                                 // Whole count above 4
   logic  full_next;

   assign wete_next = r_wete_store + 2'd1;           // Not used with edge 3
   assign le_short  = (r_wele_count < 2'd2);

   // Wait states beyond the write trailing edge
   assign cnt_long      = (r_wete_store < r_ws_count.field.lo) |
                          (r_ws_count.field.hi != '0);
   assign store_long    = (r_wete_store < r_ws_store.field.lo) |
                          (r_ws_store.field.hi != '0);
   assign cnt_long_next = (wete_next < r_ws_count.field.lo) |
                          (r_ws_count.field.hi != '0);
   assign cnt_over4     = (r_ws_count.count > 8'd4);

   // --------------------------------------
   // Decision per current state
   // --------------------------------------
   always_comb
   begin
      full_next = 1'b0;
      if (smc_nextstate == SMC_RW)                   // Only entering RW
      begin
         case (r_smc_currentstate)
            SMC_LE:
               full_next = cnt_long & le_short;
            SMC_STORE:
               full_next = cnt_long & (r_wele_count == '0);
            SMC_RW, SMC_FLOAT:
            begin
               if (valid_access)
                  full_next = 1'b0;                  // Fresh access restarts
               else if (smc_done)
                  full_next = store_long & (r_wele_store == '0);
               else if (r_wete_store == 2'd3)
                  full_next = cnt_over4 & le_short;
               else
                  full_next = cnt_long_next & le_short;
            end
            default:
               full_next = 1'b0;                     // Idle never full
         endcase
      end
   end

   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         r_full <= 1'b0;
      else
         r_full <= full_next;
   end

endmodule : smc_full_cycle

`default_nettype wire

/* smc_read_strobe.sv */
// Read strobe generation for the static memory controller
// Registers the external read strobe, released according to the
// output-enable trailing edge and the remaining wait states

`timescale 1ns/1ps
`default_nettype none

module smc_read_strobe
(
   input  wire                      sys_clk4,
   input  wire                      n_sys_reset4,
   input  wire                      valid_access,       // New request
   input  wire                      n_read,             // Low for a read
   input  wire                      n_r_read,           // Held direction
   input  wire smc_state_pkg::smc_state_t r_smc_currentstate,
   input  wire smc_state_pkg::smc_state_t smc_nextstate,
   input  wire smc_timing_pkg::edge_t     r_oete_store, // OE trailing edge
   input  wire smc_timing_pkg::ws_word_u  r_ws_store,   // Stored wait states
   input  wire smc_timing_pkg::ws_word_u  r_ws_count,   // Live wait-state count
   output logic                     smc_n_rd            // Read strobe, active low
);

   import smc_state_pkg::*;

   logic from_start;                                 // Coming from LE or store
   logic store_hold;                                 // Stored word keeps strobe
   logic count_hold;                                 // Live count keeps strobe

   assign from_start = (r_smc_currentstate == SMC_LE) |
                       (r_smc_currentstate == SMC_STORE);

   // Strobe stays while OE edge has not passed
   assign store_hold = (r_oete_store <= r_ws_store.field.lo) |
                       (r_ws_store.field.hi != '0);
   assign count_hold = (r_oete_store <= r_ws_count.field.lo) |
                       (r_ws_count.field.hi != '0) |
                       (r_ws_count.count == '0);

   // --------------------------------------
   // Read strobe register
   // --------------------------------------
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         smc_n_rd <= 1'b1;
      else if (smc_nextstate != SMC_RW)
         smc_n_rd <= 1'b1;                           // Outside RW phase
      else if (valid_access)
         smc_n_rd <= n_read;
      else if (from_start)
         smc_n_rd <= store_hold ? n_r_read : 1'b1;
      else
         smc_n_rd <= count_hold ? n_r_read : 1'b1;
   end

   // No strobe unless the FSM was heading into RW
   a_rd_only_rw : assert property (@(posedge sys_clk4) disable iff (!n_sys_reset4)
      (smc_nextstate != SMC_RW) |=> smc_n_rd);

endmodule : smc_read_strobe

`default_nettype wire

/* smc_strobe.sv */
// Strobe generator of the static memory controller
// Turns controller state, request and timing fields into the read,
// write and output-enable strobes plus the held access attributes

`timescale 1ns/1ps
`default_nettype none

module smc_strobe
(
   input  wire                      sys_clk4,
   input  wire                      n_sys_reset4,       // Async, active low
   input  wire                      valid_access,
   input  wire                      n_read,
   input  wire                      cs,
   input  wire smc_state_pkg::smc_state_t r_smc_currentstate,
   input  wire smc_state_pkg::smc_state_t smc_nextstate,
   input  wire smc_timing_pkg::byte_en_t  n_be,
   input  wire smc_timing_pkg::edge_t     r_wele_count,
   input  wire smc_timing_pkg::edge_t     r_wele_store,
   input  wire smc_timing_pkg::edge_t     r_wete_store,
   input  wire smc_timing_pkg::edge_t     r_oete_store,
   input  wire smc_timing_pkg::ws_word_u  r_ws_count,
   input  wire smc_timing_pkg::ws_word_u  r_ws_store,
   input  wire                      smc_done,
   input  wire                      mac_done,
   output logic                     smc_n_rd,
   output logic                     smc_n_ext_oe,
   output logic                     smc_busy,
   output logic                     n_r_read,           // Also feeds strobes
   output logic                     r_cs,
   output logic                     r_full,
   output smc_timing_pkg::byte_en_t n_r_we,
   output logic                     n_r_wr
);

   // Access attributes and busy
   smc_cycle_hold u_cycle_hold (
      .sys_clk4      (sys_clk4),
      .n_sys_reset4  (n_sys_reset4),
      .valid_access  (valid_access),
      .n_read        (n_read),
      .cs            (cs),
      .smc_done      (smc_done),
      .mac_done      (mac_done),
      .smc_nextstate (smc_nextstate),
      .n_r_read      (n_r_read),
      .r_cs          (r_cs),
      .smc_busy      (smc_busy)
   );

   // Write side strobes
   smc_write_enable u_write_enable (
      .sys_clk4      (sys_clk4),
      .n_sys_reset4  (n_sys_reset4),
      .valid_access  (valid_access),
      .n_read        (n_read),
      .n_r_read      (n_r_read),
      .n_be          (n_be),
      .smc_nextstate (smc_nextstate),
      .n_r_we        (n_r_we),
      .n_r_wr        (n_r_wr),
      .smc_n_ext_oe  (smc_n_ext_oe)
   );

   smc_full_cycle u_full_cycle (
      .sys_clk4           (sys_clk4),
      .n_sys_reset4       (n_sys_reset4),
      .valid_access       (valid_access),
      .smc_done           (smc_done),
      .r_smc_currentstate (r_smc_currentstate),
      .smc_nextstate      (smc_nextstate),
      .r_wele_count       (r_wele_count),
      .r_wele_store       (r_wele_store),
      .r_wete_store       (r_wete_store),
      .r_ws_count         (r_ws_count),
      .r_ws_store         (r_ws_store),
      .r_full             (r_full)
   );

   // Read side strobe
   smc_read_strobe u_read_strobe (
      .sys_clk4           (sys_clk4),
      .n_sys_reset4       (n_sys_reset4),
      .valid_access       (valid_access),
      .n_read             (n_read),
      .n_r_read           (n_r_read),
      .r_smc_currentstate (r_smc_currentstate),
      .smc_nextstate      (smc_nextstate),
      .r_oete_store       (r_oete_store),
      .r_ws_store         (r_ws_store),
      .r_ws_count         (r_ws_count),
      .smc_n_rd           (smc_n_rd)
   );

endmodule : smc_strobe

`default_nettype wire

/* tb_smc_strobe.sv */
// Testbench for the static memory controller strobe generator
// Builds a table of directed and random rows, derives the expected
// outputs from the strobe rules and checks the DUT row by row

`timescale 1ns/1ps
`default_nettype none

module tb_smc_strobe;

   import smc_state_pkg::*;
   import smc_timing_pkg::*;

   // One table row, inputs for one cycle
   typedef struct packed {
      logic       va;
      logic       nrd;
      logic       cs;
      smc_state_t cur;
      smc_state_t nxt;
      byte_en_t   nbe;
      edge_t      wele_c;
      edge_t      wele_s;
      edge_t      wete;
      edge_t      oete;
      logic [7:0] wsc;
      logic [7:0] wss;
      logic       done;
      logic       mac;
   } stim_t;

   // Expected outputs after the next edge
   typedef struct packed {
      logic     n_rd;
      logic     ext_oe;
      logic     busy;
      logic     r_read;
      logic     r_cs;
      logic     full;
      byte_en_t we;
      logic     wr;
   } exp_t;

   logic sys_clk4 = 1'b0;
   logic n_sys_reset4;
   logic valid_access, n_read, cs, smc_done, mac_done;
   smc_state_t r_smc_currentstate, smc_nextstate;
   byte_en_t n_be, n_r_we;
   edge_t r_wele_count, r_wele_store, r_wete_store, r_oete_store;
   ws_word_u r_ws_count, r_ws_store;
   logic smc_n_rd, smc_n_ext_oe, smc_busy, n_r_read, r_cs, r_full, n_r_wr;

   stim_t rows[$];                                   // Stimulus table
   exp_t  expect_q[$];                               // Expected values
   int    cycles = 0;
   int    limit  = 1000;                             // Replaced once table known

   always #50 sys_clk4 = ~sys_clk4;                  // 100 ns period

   smc_strobe UUT (.*);

   // --------------------------------------
   // Timeout
   // --------------------------------------
   always @(posedge sys_clk4)
   begin
      cycles <= cycles + 1;
      if (cycles > limit)
      begin
         $display("Run did not finish within %0d cycles", limit);
         $display("Something failed");
         $fatal(1, "timeout");
      end
   end

   task automatic add_row(input logic va, input logic nrd, input logic c,
                          input smc_state_t cur, input smc_state_t nxt,
                          input byte_en_t nbe, input edge_t wele_c, input edge_t wele_s,
                          input edge_t wete, input edge_t oete,
                          input logic [7:0] wsc, input logic [7:0] wss,
                          input logic done, input logic mac);
      stim_t s;
      s = '{va, nrd, c, cur, nxt, nbe, wele_c, wele_s, wete, oete, wsc, wss, done, mac};
      rows.push_back(s);
   endtask

   // Reference for one cycle, held_rd and held_cs are the register values
   function automatic exp_t predict(input stim_t s, input logic held_rd, input logic held_cs);
      exp_t e;
      logic new_wr, old_wr, wr_on, long_c, long_s, long_n, keep;
      new_wr   = s.va & s.nrd;
      old_wr   = ~s.va & held_rd;
      wr_on    = (s.nxt != SMC_STORE) && (new_wr || old_wr);
      e.we     = wr_on ? s.nbe : 4'hF;
      e.wr     = ~wr_on;
      e.ext_oe = ~((s.nxt != SMC_STORE) && (new_wr || (old_wr && s.nxt != SMC_IDLE)));
      e.busy   = (s.nxt != SMC_IDLE);
      if (s.va)
      begin
         e.r_read = s.nrd;
         e.r_cs   = s.cs;
      end
      else if (s.done && s.mac)
      begin
         e.r_read = 1'b0;
         e.r_cs   = 1'b0;
      end
      else
      begin
         e.r_read = held_rd;
         e.r_cs   = held_cs;
      end
      // Full-cycle rule table
      long_c = (int'(s.wete) < int'(s.wsc[1:0])) || (s.wsc[7:2] != 6'd0);
      long_s = (int'(s.wete) < int'(s.wss[1:0])) || (s.wss[7:2] != 6'd0);
      long_n = (int'(s.wete) + 1 < int'(s.wsc[1:0])) || (s.wsc[7:2] != 6'd0);
      e.full = 1'b0;
      if (s.nxt == SMC_RW)
      begin
         if (s.cur == SMC_LE)
            e.full = long_c && (s.wele_c < 2);
         else if (s.cur == SMC_STORE)
            e.full = long_c && (s.wele_c == 0);
         else if (s.cur == SMC_RW || s.cur == SMC_FLOAT)
         begin
            if (s.va)
               e.full = 1'b0;
            else if (s.done)
               e.full = long_s && (s.wele_s == 0);
            else if (s.wete == 3)
               e.full = (s.wsc > 8'd4) && (s.wele_c < 2);
            else
               e.full = long_n && (s.wele_c < 2);
         end
      end
      // Read strobe
      if (s.nxt != SMC_RW)
         e.n_rd = 1'b1;
      else if (s.va)
         e.n_rd = s.nrd;
      else
      begin
         if (s.cur == SMC_LE || s.cur == SMC_STORE)
            keep = (s.oete <= s.wss[1:0]) || (s.wss[7:2] != 6'd0);
         else
            keep = (s.oete <= s.wsc[1:0]) || (s.wsc[7:2] != 6'd0) || (s.wsc == 8'd0);
         e.n_rd = keep ? held_rd : 1'b1;
      end
      return e;
   endfunction

   function automatic smc_state_t pick_state(input logic [2:0] k);
      case (k)
         3'd0:    return SMC_IDLE;
         3'd1:    return SMC_LE;
         3'd2:    return SMC_RW;
         3'd3:    return SMC_STORE;
         default: return SMC_FLOAT;
      endcase
   endfunction

   task automatic fail_now(input string what);
      $display("error at %0t: %s", $time, what);
      $display("Something failed");
      $fatal(1, "check failed");
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp)
      else fail_now($sformatf("%s is %b, expected %b", name, got, exp));
   endtask

   task automatic check_row(input exp_t e);
      assert (n_r_we === e.we)
      else fail_now($sformatf("n_r_we is %h, expected %h", n_r_we, e.we));
      check_bit("smc_n_rd", smc_n_rd, e.n_rd);
      check_bit("smc_n_ext_oe", smc_n_ext_oe, e.ext_oe);
      check_bit("smc_busy", smc_busy, e.busy);
      check_bit("n_r_read", n_r_read, e.r_read);
      check_bit("r_cs", r_cs, e.r_cs);
      check_bit("r_full", r_full, e.full);
      check_bit("n_r_wr", n_r_wr, e.wr);
   endtask

   task automatic drive(input stim_t s);
      valid_access       = s.va;
      n_read             = s.nrd;
      cs                 = s.cs;
      r_smc_currentstate = s.cur;
      smc_nextstate      = s.nxt;
      n_be               = s.nbe;
      r_wele_count       = s.wele_c;
      r_wele_store       = s.wele_s;
      r_wete_store       = s.wete;
      r_oete_store       = s.oete;
      r_ws_count         = s.wsc;
      r_ws_store         = s.wss;
      smc_done           = s.done;
      mac_done           = s.mac;
   endtask

   initial
   begin
      logic [31:0] r;
      stim_t s;
      exp_t  e;
      logic  hr;
      logic  hc;
      void'($urandom(61));
      drive('{1'b0, 1'b0, 1'b0, SMC_IDLE, SMC_IDLE, 4'hF, 2'd0, 2'd0, 2'd0, 2'd0,
              8'd0, 8'd0, 1'b0, 1'b0});
      n_sys_reset4 = 1'b0;

      // Hold and write enables
      add_row(1, 1, 1, SMC_IDLE, SMC_LE, 4'hC, 0, 0, 0, 0, 8'h00, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_LE, SMC_RW, 4'h3, 0, 0, 0, 0, 8'h01, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_RW, SMC_RW, 4'h3, 0, 0, 0, 0, 8'h00, 8'h00, 0, 1);
      add_row(0, 0, 0, SMC_RW, SMC_STORE, 4'h5, 0, 0, 0, 0, 8'h00, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_STORE, SMC_IDLE, 4'h5, 0, 0, 0, 0, 8'h00, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_IDLE, SMC_IDLE, 4'h5, 0, 0, 0, 0, 8'h00, 8'h00, 1, 1);
      // Read strobe edge rules
      add_row(1, 0, 1, SMC_IDLE, SMC_RW, 4'hF, 0, 0, 0, 0, 8'h00, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_LE, SMC_RW, 4'hF, 0, 0, 0, 2, 8'h00, 8'h01, 0, 0);
      add_row(0, 0, 0, SMC_LE, SMC_RW, 4'hF, 0, 0, 0, 2, 8'h00, 8'h02, 0, 0);
      add_row(0, 0, 0, SMC_STORE, SMC_RW, 4'hF, 0, 0, 0, 3, 8'h00, 8'h04, 0, 0);
      add_row(0, 0, 0, SMC_RW, SMC_RW, 4'hF, 0, 0, 0, 3, 8'h00, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_RW, SMC_RW, 4'hF, 0, 0, 0, 3, 8'h02, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_FLOAT, SMC_IDLE, 4'hF, 0, 0, 0, 0, 8'h00, 8'h00, 1, 1);
      // Full-cycle thresholds
      add_row(0, 0, 0, SMC_LE, SMC_RW, 4'hF, 0, 0, 2, 0, 8'h02, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_LE, SMC_RW, 4'hF, 1, 0, 2, 0, 8'h03, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_LE, SMC_RW, 4'hF, 2, 0, 2, 0, 8'h03, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_STORE, SMC_RW, 4'hF, 1, 0, 0, 0, 8'h04, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_STORE, SMC_RW, 4'hF, 0, 0, 0, 0, 8'h04, 8'h00, 0, 0);
      add_row(1, 1, 1, SMC_RW, SMC_RW, 4'h0, 0, 0, 0, 0, 8'h04, 8'h04, 0, 0);
      add_row(0, 0, 0, SMC_FLOAT, SMC_RW, 4'hF, 0, 0, 1, 0, 8'h00, 8'h04, 1, 0);
      add_row(0, 0, 0, SMC_FLOAT, SMC_RW, 4'hF, 0, 1, 1, 0, 8'h00, 8'h04, 1, 0);
      add_row(0, 0, 0, SMC_RW, SMC_RW, 4'hF, 0, 0, 3, 0, 8'h04, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_RW, SMC_RW, 4'hF, 0, 0, 3, 0, 8'h05, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_RW, SMC_RW, 4'hF, 0, 0, 1, 0, 8'h02, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_RW, SMC_RW, 4'hF, 0, 0, 1, 0, 8'h03, 8'h00, 0, 0);
      add_row(0, 0, 0, SMC_LE, SMC_IDLE, 4'hF, 0, 0, 0, 0, 8'hFF, 8'hFF, 0, 0);

      // Random rows
      for (int i = 0; i < 200; i++)
      begin
         r = $urandom;
         s.va     = (r[1:0] == 2'd0);
         s.nrd    = r[2];
         s.cs     = r[3];
         s.cur    = pick_state(r[6:4]);
         s.nxt    = pick_state(r[9:7]);
         s.nbe    = r[13:10];
         s.wele_c = r[15:14];
         s.wele_s = r[17:16];
         s.wete   = r[19:18];
         s.oete   = r[21:20];
         s.done   = r[22];
         s.mac    = r[23];
         r = $urandom;
         s.wsc    = r[31:30] == 2'd0 ? r[7:0] : {6'd0, r[1:0]};
         s.wss    = r[29:28] == 2'd0 ? r[15:8] : {5'd0, r[10:8]};
         rows.push_back(s);
      end

      // Expected values with the held registers tracked across rows
      hr = 1'b0;
      hc = 1'b0;
      foreach (rows[i])
      begin
         e = predict(rows[i], hr, hc);
         expect_q.push_back(e);
         hr = e.r_read;
         hc = e.r_cs;
      end
      limit = rows.size() + 20;

      repeat (3) @(posedge sys_clk4);
      #5 n_sys_reset4 = 1'b1;
      check_row('{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, BYTE_NONE, 1'b1});

      // --------------------------------------
      // Apply rows, check one edge later
      // --------------------------------------
      for (int i = 0; i <= rows.size(); i++)
      begin
         if (i > 0)
         begin
            @(posedge sys_clk4);
            #5;
            check_row(expect_q[i-1]);
         end
         if (i < rows.size())
            drive(rows[i]);
      end

      $display("Everything OK");
      $finish;
   end

endmodule : tb_smc_strobe

`default_nettype wire

/* smc_strobe.f */
smc_state_pkg.sv
smc_timing_pkg.sv
smc_cycle_hold.sv
smc_write_enable.sv
smc_full_cycle.sv
smc_read_strobe.sv
smc_strobe.sv
tb_smc_strobe.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the strobe generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_smc_strobe \
   -Mdir obj_dir \
   -f smc_strobe.f
status=$?
if [ $status -ne 0 ]; then
   echo "Build failed"
   exit $status
fi

./obj_dir/Vtb_smc_strobe
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed"
   exit $status
fi

exit 0
